// ==== files.f ====
+incdir+logic
logic/isa_pkg.sv
logic/issue_pkg.sv
logic/regfile_read_if.sv
logic/int_regfile.sv
logic/issue_control.sv
logic/operand_stage.sv
logic/issue_operands_top.sv
tb/tb_issue_operands.sv

// ==== logic/int_regfile.sv ====
/* integer register file: x0 hardwired to zero, commit write ports, async reads */

`default_nettype none
`timescale 1ns/1ns

`include "issue_settings.svh"

module int_regfile import isa_pkg::*; (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    regfile_read_if.rf                       rd,
    input  reg_addr_t [`NR_COMMIT_PORTS-1:0] waddr_i,
    input  xlen_t     [`NR_COMMIT_PORTS-1:0] wdata_i,
    input  logic      [`NR_COMMIT_PORTS-1:0] we_i
);

    // x0 has no storage
    xlen_t [`NR_REGS-1:1] regs_q;

    // ------------------------------
    // write side
    // ------------------------------
    // ports are walked in order, so the highest port wins a collision
    always_ff @(posedge clk_i or negedge rst_ni) begin : reg_write
        if (!rst_ni) begin
            regs_q <= '0;
        end else begin
            for (int unsigned p = 0; p < `NR_COMMIT_PORTS; p++) begin
                // writes to x0 are dropped
                if (we_i[p] && (waddr_i[p] != '0)) begin
                    regs_q[waddr_i[p]] <= wdata_i[p];
                end
            end
        end
    end

    // ------------------------------
    // read side
    // ------------------------------
    for (genvar r = 0; r < 2; r++) begin : gen_read_port
        // new data shows up the cycle after the write enable
        assign rd.rdata[r] = (rd.raddr[r] == '0) ? '0 : regs_q[rd.raddr[r]];
    end

    // the top commit port keeps its data whatever the lower ports wrote
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (we_i[`NR_COMMIT_PORTS-1] && (waddr_i[`NR_COMMIT_PORTS-1] != '0))
        |=> (regs_q[$past(waddr_i[`NR_COMMIT_PORTS-1])]
             == $past(wdata_i[`NR_COMMIT_PORTS-1])))
        else $error("top commit port lost a write collision");

endmodule

`default_nettype wire

// ==== logic/isa_pkg.sv ====
/* architectural types: register index, data word, unit and operation enums,
   and the per-register clobber list */

`default_nettype none

`include "issue_settings.svh"

package isa_pkg;

    typedef logic [`REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [`XLEN-1:0]          xlen_t;

    // unit that executes an instruction
    typedef enum logic [3:0] {
        NONE,
        LOAD,
        STORE,
        ALU,
        CTRL_FLOW,
        MULT,
        CSR
    } fu_t;

    // reduced operation set, encoding kept 7 bits wide
    typedef enum logic [6:0] {
        ADD,
        SUB,
        ANDL,
        ORL,
        XORL,
        SLL,
        SRL,
        SLTS,
        LD,
        SD,
        JALR,
        EQ,
        MUL,
        CSR_RW
    } fu_op_t;

    // one entry per register, names the unit that will write it
    typedef fu_t [`NR_REGS-1:0] clobber_t;

endpackage

`default_nettype wire

// ==== logic/issue_control.sv ====
/* issue decision: source hazards, unit busy, write-after-write with commit bypass,
   ack and the registered one-hot unit strobes */

`default_nettype none
`timescale 1ns/1ns

`include "issue_settings.svh"

module issue_control import isa_pkg::*, issue_pkg::*; (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             flush_i,
    input  issue_entry_t                     issue_entry_i,
    input  logic                             issue_valid_i,
    output logic                             issue_ack_o,
    input  clobber_t                         rd_clobber_i,
    input  logic                             rs1_valid_i,
    input  logic                             rs2_valid_i,
    input  logic                             flu_ready_i,
    input  logic                             lsu_ready_i,
    input  reg_addr_t [`NR_COMMIT_PORTS-1:0] waddr_i,
    input  logic      [`NR_COMMIT_PORTS-1:0] we_i,
    output logic                             fwd_rs1_o,
    output logic                             fwd_rs2_o,
    output logic                             alu_valid_o,
    output logic                             branch_valid_o,
    output logic                             lsu_valid_o,
    output logic                             mult_valid_o,
    output logic                             csr_valid_o
);

    logic stall;
    logic fu_busy;
    // rd has no pending writer in the scoreboard
    logic rd_free;
    // a commit port retires rd in this very cycle
    logic rd_committing;

    // ------------------------------
    // source operand hazards
    // ------------------------------
    always_comb begin : hazard_check
        stall     = 1'b0;
        fwd_rs1_o = 1'b0;
        fwd_rs2_o = 1'b0;
        // a zimm in the rs1 field never waits on a register
        if (!issue_entry_i.use_zimm && (rd_clobber_i[issue_entry_i.rs1] != NONE)) begin
            // csr results only reach the operands through the register file
            if (rs1_valid_i && (rd_clobber_i[issue_entry_i.rs1] != CSR)) begin
                fwd_rs1_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
        if (rd_clobber_i[issue_entry_i.rs2] != NONE) begin
            if (rs2_valid_i && (rd_clobber_i[issue_entry_i.rs2] != CSR)) begin
                fwd_rs2_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // fixed latency units share flu_ready_i
    always_comb begin : unit_busy
        unique case (issue_entry_i.fu)
            ALU, CTRL_FLOW, CSR, MULT: fu_busy = !flu_ready_i;
            LOAD, STORE:               fu_busy = !lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // ------------------------------
    // write-after-write on rd
    // ------------------------------
    assign rd_free = (rd_clobber_i[issue_entry_i.rd] == NONE);

    always_comb begin : commit_bypass
        rd_committing = 1'b0;
        for (int unsigned p = 0; p < `NR_COMMIT_PORTS; p++) begin
            if (we_i[p] && (waddr_i[p] == issue_entry_i.rd)) begin
                rd_committing = 1'b1;
            end
        end
    end

    always_comb begin : issue_ack
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (!stall && !fu_busy && (rd_free || rd_committing)) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less entries leave without a unit
            if (issue_entry_i.ex_valid || (issue_entry_i.fu == NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // a mult in flight owns the fixed latency result bus
        if (mult_valid_o && (issue_entry_i.fu != MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

    // ------------------------------
    // unit strobes, one cycle later
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : unit_valid
        if (!rst_ni) begin
            alu_valid_o    <= 1'b0;
            branch_valid_o <= 1'b0;
            lsu_valid_o    <= 1'b0;
            mult_valid_o   <= 1'b0;
            csr_valid_o    <= 1'b0;
        end else begin
            alu_valid_o    <= 1'b0;
            branch_valid_o <= 1'b0;
            lsu_valid_o    <= 1'b0;
            mult_valid_o   <= 1'b0;
            csr_valid_o    <= 1'b0;
            // flush wins over any dispatch
            if (!flush_i && issue_valid_i && issue_ack_o && !issue_entry_i.ex_valid) begin
                case (issue_entry_i.fu)
                    ALU:         alu_valid_o    <= 1'b1;
                    CTRL_FLOW:   branch_valid_o <= 1'b1;
                    LOAD, STORE: lsu_valid_o    <= 1'b1;
                    MULT:        mult_valid_o   <= 1'b1;
                    CSR:         csr_valid_o    <= 1'b1;
                    default:     ;
                endcase
            end
        end
    end

    // at most one unit started per cycle
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o}))
        else $error("more than one unit valid");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> !(alu_valid_o || branch_valid_o || lsu_valid_o || mult_valid_o
                      || csr_valid_o))
        else $error("unit valid raised after flush");

endmodule

`default_nettype wire

// ==== logic/issue_operands_top.sv ====
/* issue and operand-read stage top: register file, issue control and operand stage */

`default_nettype none
`timescale 1ns/1ns

`include "issue_settings.svh"

module issue_operands_top import isa_pkg::*, issue_pkg::*; (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             flush_i,
    // entry from the scoreboard
    input  issue_entry_t                     issue_entry_i,
    input  logic                             issue_valid_i,
    output logic                             issue_ack_o,
    // scoreboard lookup for forwarding
    output reg_addr_t                        rs1_o,
    input  xlen_t                            rs1_data_i,
    input  logic                             rs1_valid_i,
    output reg_addr_t                        rs2_o,
    input  xlen_t                            rs2_data_i,
    input  logic                             rs2_valid_i,
    input  clobber_t                         rd_clobber_i,
    // to the units
    output fu_data_t                         fu_data_o,
    output logic [`VLEN-1:0]                 pc_o,
    input  logic                             flu_ready_i,
    input  logic                             lsu_ready_i,
    output logic                             alu_valid_o,
    output logic                             branch_valid_o,
    output logic                             lsu_valid_o,
    output logic                             mult_valid_o,
    output logic                             csr_valid_o,
    // commit write ports
    input  reg_addr_t [`NR_COMMIT_PORTS-1:0] waddr_i,
    input  xlen_t     [`NR_COMMIT_PORTS-1:0] wdata_i,
    input  logic      [`NR_COMMIT_PORTS-1:0] we_i
);

    logic fwd_rs1;
    logic fwd_rs2;

    regfile_read_if rf_rd_if ();

    // scoreboard is searched with the entry's own sources
    assign rs1_o = issue_entry_i.rs1;
    assign rs2_o = issue_entry_i.rs2;

    int_regfile regfile_i (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .rd      (rf_rd_if.rf),
        .waddr_i (waddr_i),
        .wdata_i (wdata_i),
        .we_i    (we_i)
    );

    issue_control control_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .issue_entry_i  (issue_entry_i),
        .issue_valid_i  (issue_valid_i),
        .issue_ack_o    (issue_ack_o),
        .rd_clobber_i   (rd_clobber_i),
        .rs1_valid_i    (rs1_valid_i),
        .rs2_valid_i    (rs2_valid_i),
        .flu_ready_i    (flu_ready_i),
        .lsu_ready_i    (lsu_ready_i),
        .waddr_i        (waddr_i),
        .we_i           (we_i),
        .fwd_rs1_o      (fwd_rs1),
        .fwd_rs2_o      (fwd_rs2),
        .alu_valid_o    (alu_valid_o),
        .branch_valid_o (branch_valid_o),
        .lsu_valid_o    (lsu_valid_o),
        .mult_valid_o   (mult_valid_o),
        .csr_valid_o    (csr_valid_o)
    );

    operand_stage operands_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .issue_entry_i (issue_entry_i),
        .rf            (rf_rd_if.stage),
        .fwd_rs1_i     (fwd_rs1),
        .fwd_rs2_i     (fwd_rs2),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .fu_data_o     (fu_data_o),
        .pc_o          (pc_o)
    );

endmodule

`default_nettype wire

// ==== logic/issue_pkg.sv ====
/* scoreboard-side types: the issue entry and the data word handed to the units */

`default_nettype none

`include "issue_settings.svh"

package issue_pkg;

    import isa_pkg::*;

    // ------------------------------
    // entry as it leaves the scoreboard
    // ------------------------------
    typedef struct packed {
        fu_t                       fu;
        fu_op_t                    op;
        reg_addr_t                 rs1;
        reg_addr_t                 rs2;
        reg_addr_t                 rd;
        // holds the immediate until the result comes back
        xlen_t                     result;
        logic                      use_imm;
        logic                      use_pc;
        // rs1 field carries a csr zimm instead of a register
        logic                      use_zimm;
        logic [`VLEN-1:0]          pc;
        logic [`TRANS_ID_BITS-1:0] trans_id;
        // an earlier stage already raised an exception
        logic                      ex_valid;
    } issue_entry_t;

    // ------------------------------
    // ID/EX payload to the units
    // ------------------------------
    typedef struct packed {
        fu_t                       fu;
        fu_op_t                    operator;
        xlen_t                     operand_a;
        xlen_t                     operand_b;
        xlen_t                     imm;
        logic [`TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

endpackage

`default_nettype wire

// ==== logic/issue_settings.svh ====
/* width, register count, commit port and tag size constants for the issue stage */

`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// data path width of the integer core
`define XLEN 64

// architectural register file
`define REG_ADDR_BITS 5
`define NR_REGS 32

// write ports coming back from commit
`define NR_COMMIT_PORTS 2

// scoreboard tag width
`define TRANS_ID_BITS 3

// virtual address width, sign-extended to XLEN when used as an operand
`define VLEN 39

`endif

// ==== logic/operand_stage.sv ====
/* operand forwarding and immediate selection, plus the ID/EX payload register */

`default_nettype none
`timescale 1ns/1ns

`include "issue_settings.svh"

module operand_stage import isa_pkg::*, issue_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  issue_entry_t     issue_entry_i,
    regfile_read_if.stage    rf,
    input  logic             fwd_rs1_i,
    input  logic             fwd_rs2_i,
    input  xlen_t            rs1_data_i,
    input  xlen_t            rs2_data_i,
    output fu_data_t         fu_data_o,
    output logic [`VLEN-1:0] pc_o
);

    xlen_t operand_a;
    xlen_t operand_b;

    // register file lookup straight from the entry
    assign rf.raddr[0] = issue_entry_i.rs1;
    assign rf.raddr[1] = issue_entry_i.rs2;

    // ------------------------------
    // operand select
    // ------------------------------
    always_comb begin : operand_a_select
        if (issue_entry_i.use_zimm) begin
            // csr immediate, zero extended
            operand_a = {{(`XLEN-`REG_ADDR_BITS){1'b0}}, issue_entry_i.rs1};
        end else if (issue_entry_i.use_pc) begin
            operand_a = {{(`XLEN-`VLEN){issue_entry_i.pc[`VLEN-1]}}, issue_entry_i.pc};
        end else if (fwd_rs1_i) begin
            operand_a = rs1_data_i;
        end else begin
            operand_a = rf.rdata[0];
        end
    end

    // stores and branches keep rs2 in operand b, their immediate goes via imm
    always_comb begin : operand_b_select
        if (issue_entry_i.use_imm && (issue_entry_i.fu != STORE)
                && (issue_entry_i.fu != CTRL_FLOW)) begin
            operand_b = issue_entry_i.result;
        end else if (fwd_rs2_i) begin
            operand_b = rs2_data_i;
        end else begin
            operand_b = rf.rdata[1];
        end
    end

    // ------------------------------
    // ID/EX register
    // ------------------------------
    // loads every cycle, the unit strobes decide whether it is consumed
    always_ff @(posedge clk_i or negedge rst_ni) begin : id_ex_reg
        if (!rst_ni) begin
            fu_data_o.fu        <= NONE;
            fu_data_o.operator  <= ADD;
            fu_data_o.operand_a <= '0;
            fu_data_o.operand_b <= '0;
            fu_data_o.imm       <= '0;
            fu_data_o.trans_id  <= '0;
            pc_o                <= '0;
        end else begin
            fu_data_o.fu        <= issue_entry_i.fu;
            fu_data_o.operator  <= issue_entry_i.op;
            fu_data_o.operand_a <= operand_a;
            fu_data_o.operand_b <= operand_b;
            fu_data_o.imm       <= issue_entry_i.result;
            fu_data_o.trans_id  <= issue_entry_i.trans_id;
            pc_o                <= issue_entry_i.pc;
        end
    end

    // a branch started by the issue control must see clean operands
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (fu_data_o.fu == CTRL_FLOW) |-> !$isunknown({fu_data_o.operand_a, fu_data_o.operand_b}))
        else $error("unknown operand on a branch");

endmodule

`default_nettype wire

// ==== logic/regfile_read_if.sv ====
/* two-port combinational read path between the operand stage and the register file */

`default_nettype none
`timescale 1ns/1ns

interface regfile_read_if import isa_pkg::*; ();

    // port 0 serves rs1, port 1 serves rs2
    reg_addr_t [1:0] raddr;
    xlen_t     [1:0] rdata;

    // operand side picks the registers
    modport stage (
        output raddr,
        input  rdata
    );

    // register file answers in the same cycle
    modport rf (
        input  raddr,
        output rdata
    );

endinterface

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# builds the issue stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_issue_operands \
    --Mdir obj_dir -o tb_issue_operands
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_issue_operands > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi

// ==== tb/tb_issue_operands.sv ====
/* testbench for the issue stage: seeded random stimulus, reference model with a
   shadow register file, compare tasks and a watchdog */

`default_nettype none
`timescale 1ns/1ns

`include "issue_settings.svh"

module tb_issue_operands import isa_pkg::*, issue_pkg::*; ();

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_CYCLES      = 2000;
    // margin covers the reset phase
    localparam int WATCHDOG_CYCLES = NUM_CYCLES + 100;

    logic clk = 1'b0;
    logic rst_n;
    logic flush;
    issue_entry_t issue_entry;
    logic issue_valid;
    logic issue_ack;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t rs1_data;
    xlen_t rs2_data;
    logic rs1_valid;
    logic rs2_valid;
    clobber_t clobber;
    fu_data_t fu_data;
    logic [`VLEN-1:0] pc;
    logic flu_ready;
    logic lsu_ready;
    logic alu_valid;
    logic branch_valid;
    logic lsu_valid;
    logic mult_valid;
    logic csr_valid;
    reg_addr_t [`NR_COMMIT_PORTS-1:0] waddr;
    xlen_t     [`NR_COMMIT_PORTS-1:0] wdata;
    logic      [`NR_COMMIT_PORTS-1:0] we;

    integer seed = 15494;

    // model state, what the DUT should show after the next rising edge
    logic exp_alu_q;
    logic exp_branch_q;
    logic exp_lsu_q;
    logic exp_mult_q;
    logic exp_csr_q;
    fu_data_t exp_fu_data_q;
    xlen_t exp_pc_q;
    xlen_t shadow [`NR_REGS];

    int unsigned num_acks;
    int unsigned num_dispatches;

    always #(CLK_PERIOD / 2) clk = ~clk;

    issue_operands_top dut_i (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .flush_i        (flush),
        .issue_entry_i  (issue_entry),
        .issue_valid_i  (issue_valid),
        .issue_ack_o    (issue_ack),
        .rs1_o          (rs1_addr),
        .rs1_data_i     (rs1_data),
        .rs1_valid_i    (rs1_valid),
        .rs2_o          (rs2_addr),
        .rs2_data_i     (rs2_data),
        .rs2_valid_i    (rs2_valid),
        .rd_clobber_i   (clobber),
        .fu_data_o      (fu_data),
        .pc_o           (pc),
        .flu_ready_i    (flu_ready),
        .lsu_ready_i    (lsu_ready),
        .alu_valid_o    (alu_valid),
        .branch_valid_o (branch_valid),
        .lsu_valid_o    (lsu_valid),
        .mult_valid_o   (mult_valid),
        .csr_valid_o    (csr_valid),
        .waddr_i        (waddr),
        .wdata_i        (wdata),
        .we_i           (we)
    );

    // ------------------------------
    // random helpers
    // ------------------------------
    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        logic [31:0] r;
        r = $random(seed);
        return r % n;
    endfunction

    function automatic xlen_t rand_word();
        return {rand32(), rand32()};
    endfunction

    // half of the picks land in x0..x7 so collisions and bypasses happen
    function automatic reg_addr_t rand_reg();
        if (rand_below(2) == 0) begin
            return reg_addr_t'(rand_below(8));
        end
        return reg_addr_t'(rand_below(`NR_REGS));
    endfunction

    // ------------------------------
    // checking
    // ------------------------------
    task automatic fail_run();
        $display("Test FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_logic(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %b, got %b", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_fu_data(input string name, input fu_data_t exp, input fu_data_t act);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, act);
            fail_run();
        end
    endtask

    // registered outputs against the prediction of the previous cycle
    task automatic check_registered();
        check_logic("alu_valid_o", exp_alu_q, alu_valid);
        check_logic("branch_valid_o", exp_branch_q, branch_valid);
        check_logic("lsu_valid_o", exp_lsu_q, lsu_valid);
        check_logic("mult_valid_o", exp_mult_q, mult_valid);
        check_logic("csr_valid_o", exp_csr_q, csr_valid);
        check_word("fu_data_o.operand_a", exp_fu_data_q.operand_a, fu_data.operand_a);
        check_word("fu_data_o.operand_b", exp_fu_data_q.operand_b, fu_data.operand_b);
        check_word("pc_o", exp_pc_q, xlen_t'(pc));
        check_fu_data("fu_data_o", exp_fu_data_q, fu_data);
    endtask

    // ------------------------------
    // reference model
    // ------------------------------
    // ack and forwarding for the inputs of this cycle
    task automatic model_issue(output logic ack, output logic fwd1, output logic fwd2);
        logic stall;
        logic busy;
        logic rd_ok;
        fu_t  c1;
        fu_t  c2;
        stall = 1'b0;
        fwd1  = 1'b0;
        fwd2  = 1'b0;
        c1    = clobber[issue_entry.rs1];
        c2    = clobber[issue_entry.rs2];
        // zimm is no register, csr results cannot be forwarded
        if (!issue_entry.use_zimm && (c1 != NONE)) begin
            if (rs1_valid && (c1 != CSR)) fwd1 = 1'b1;
            else stall = 1'b1;
        end
        if (c2 != NONE) begin
            if (rs2_valid && (c2 != CSR)) fwd2 = 1'b1;
            else stall = 1'b1;
        end
        case (issue_entry.fu)
            ALU, CTRL_FLOW, CSR, MULT: busy = !flu_ready;
            LOAD, STORE:               busy = !lsu_ready;
            default:                   busy = 1'b0;
        endcase
        // rd free, or retired by a commit port right now
        rd_ok = (clobber[issue_entry.rd] == NONE);
        for (int p = 0; p < `NR_COMMIT_PORTS; p++) begin
            if (we[p] && (waddr[p] == issue_entry.rd)) rd_ok = 1'b1;
        end
        ack = issue_valid && ((!stall && !busy && rd_ok) || issue_entry.ex_valid
                              || (issue_entry.fu == NONE));
        // only another mult may follow a mult
        if (exp_mult_q && (issue_entry.fu != MULT)) ack = 1'b0;
    endtask

    task automatic predict_next(input logic ack, input logic fwd1, input logic fwd2);
        logic dispatch;
        xlen_t op_a;
        xlen_t op_b;
        dispatch     = !flush && ack && !issue_entry.ex_valid;
        exp_alu_q    = dispatch && (issue_entry.fu == ALU);
        exp_branch_q = dispatch && (issue_entry.fu == CTRL_FLOW);
        exp_lsu_q    = dispatch && ((issue_entry.fu == LOAD) || (issue_entry.fu == STORE));
        exp_mult_q   = dispatch && (issue_entry.fu == MULT);
        exp_csr_q    = dispatch && (issue_entry.fu == CSR);
        if (exp_alu_q || exp_branch_q || exp_lsu_q || exp_mult_q || exp_csr_q) begin
            num_dispatches++;
        end
        // operand a priority: zimm, pc, forwarded, register file
        if (issue_entry.use_zimm) op_a = xlen_t'(issue_entry.rs1);
        else if (issue_entry.use_pc) op_a = xlen_t'($signed(issue_entry.pc));
        else if (fwd1) op_a = rs1_data;
        else op_a = shadow[issue_entry.rs1];
        // stores and branches keep rs2 as operand b
        if (issue_entry.use_imm && (issue_entry.fu != STORE) && (issue_entry.fu != CTRL_FLOW))
            op_b = issue_entry.result;
        else if (fwd2) op_b = rs2_data;
        else op_b = shadow[issue_entry.rs2];
        exp_fu_data_q.fu        = issue_entry.fu;
        exp_fu_data_q.operator  = issue_entry.op;
        exp_fu_data_q.operand_a = op_a;
        exp_fu_data_q.operand_b = op_b;
        exp_fu_data_q.imm       = issue_entry.result;
        exp_fu_data_q.trans_id  = issue_entry.trans_id;
        exp_pc_q                = xlen_t'(issue_entry.pc);
        // commit writes land at the next edge, the higher port last
        for (int p = 0; p < `NR_COMMIT_PORTS; p++) begin
            if (we[p] && (waddr[p] != '0)) shadow[waddr[p]] = wdata[p];
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic drive_random();
        issue_entry_t e;
        clobber_t     c;
        xlen_t        w;
        int unsigned  r;
        w          = rand_word();
        e.fu       = fu_t'(rand_below(7));
        e.op       = fu_op_t'(rand_below(14));
        e.rs1      = rand_reg();
        e.rs2      = rand_reg();
        e.rd       = rand_reg();
        e.result   = rand_word();
        e.use_imm  = (rand_below(2) == 0);
        e.use_pc   = (rand_below(8) == 0);
        e.use_zimm = (rand_below(8) == 0);
        e.pc       = w[`VLEN-1:0];
        e.trans_id = w[63:64-`TRANS_ID_BITS];
        e.ex_valid = (rand_below(16) == 0);
        // clobbers mostly NONE, now and then a csr
        for (int i = 0; i < `NR_REGS; i++) begin
            r = rand_below(16);
            if (r < 11) c[i] = NONE;
            else if (r == 15) c[i] = CSR;
            else c[i] = fu_t'(1 + rand_below(5));
        end
        issue_entry <= e;
        clobber     <= c;
        issue_valid <= (rand_below(4) != 0);
        flush       <= (rand_below(16) == 0);
        rs1_valid   <= (rand_below(4) != 0);
        rs2_valid   <= (rand_below(4) != 0);
        rs1_data    <= rand_word();
        rs2_data    <= rand_word();
        flu_ready   <= (rand_below(4) != 0);
        lsu_ready   <= (rand_below(4) != 0);
        for (int p = 0; p < `NR_COMMIT_PORTS; p++) begin
            we[p]    <= (rand_below(2) == 0);
            waddr[p] <= rand_reg();
            wdata[p] <= rand_word();
        end
    endtask

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        fail_run();
    end

    initial begin : main
        logic ack;
        logic fwd1;
        logic fwd2;
        rst_n       = 1'b0;
        flush       = 1'b0;
        issue_entry = '0;
        issue_valid = 1'b0;
        rs1_data    = '0;
        rs2_data    = '0;
        rs1_valid   = 1'b0;
        rs2_valid   = 1'b0;
        flu_ready   = 1'b1;
        lsu_ready   = 1'b1;
        waddr       = '0;
        wdata       = '0;
        we          = '0;
        for (int i = 0; i < `NR_REGS; i++) begin
            clobber[i] = NONE;
            shadow[i]  = '0;
        end
        // reset values of the outputs
        exp_alu_q              = 1'b0;
        exp_branch_q           = 1'b0;
        exp_lsu_q              = 1'b0;
        exp_mult_q             = 1'b0;
        exp_csr_q              = 1'b0;
        exp_fu_data_q          = '0;
        exp_fu_data_q.fu       = NONE;
        exp_fu_data_q.operator = ADD;
        exp_pc_q               = '0;
        num_acks               = 0;
        num_dispatches         = 0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        check_registered();

        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            @(posedge clk);
            rst_n <= 1'b1;
            drive_random();
            @(negedge clk);
            check_registered();
            check_word("rs1_o", xlen_t'(issue_entry.rs1), xlen_t'(rs1_addr));
            check_word("rs2_o", xlen_t'(issue_entry.rs2), xlen_t'(rs2_addr));
            model_issue(ack, fwd1, fwd2);
            check_logic("issue_ack_o", ack, issue_ack);
            if (ack) num_acks++;
            predict_next(ack, fwd1, fwd2);
        end

        $display("%0d cycles, %0d acks, %0d dispatches", NUM_CYCLES, num_acks, num_dispatches);
        // a run without a single dispatch has not exercised the strobes
        if ((num_acks == 0) || (num_dispatches == 0)) begin
            $display("the random run never acknowledged and dispatched an entry");
            fail_run();
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire
